// File: hw/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // scratch RAM is 1024 words
  localparam int RAM_ADDR_BITS = 10;

  // address map
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;  // 4 KiB window
  localparam logic [ADDR_W-1:0] LED_ADDR = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] KEY_ADDR = 32'h1000_0004;

  // peripheral widths
  localparam int LED_W = 8;
  localparam int KEY_W = 2;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // bus decoder FSM encoding
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WRESP = 2'd1;  // B pending
  localparam logic [1:0] ST_RWAIT = 2'd2;  // RAM read in flight
  localparam logic [1:0] ST_RRESP = 2'd3;  // R pending

  // one data word, seen whole or as byte lanes
  // lane 0 is the low byte
  typedef union packed {
    logic [DATA_W-1:0]      word;
    logic [STRB_W-1:0][7:0] lane;
  } bus_word_u;

endpackage

`default_nettype wire

// File: hw/bus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module bus_decoder (
  input  wire                              clk,
  input  wire                              rst_n_i,
  // write address and data
  input  wire                              awvalid_i,
  input  wire  [soc_pkg::ADDR_W-1:0]       awaddr_i,
  output logic                             awready_o,
  input  wire                              wvalid_i,
  input  wire  [soc_pkg::DATA_W-1:0]       wdata_i,
  input  wire  [soc_pkg::STRB_W-1:0]       wstrb_i,
  output logic                             wready_o,
  // write response
  output logic                             bvalid_o,
  output logic [1:0]                       bresp_o,
  input  wire                              bready_i,
  // read
  input  wire                              arvalid_i,
  input  wire  [soc_pkg::ADDR_W-1:0]       araddr_i,
  output logic                             arready_o,
  output logic                             rvalid_o,
  output logic [soc_pkg::DATA_W-1:0]       rdata_o,
  output logic [1:0]                       rresp_o,
  input  wire                              rready_i,
  // toward peripherals
  output logic [soc_pkg::RAM_ADDR_BITS-1:0] word_addr_o,
  output logic [soc_pkg::DATA_W-1:0]       wr_data_o,
  output logic [soc_pkg::STRB_W-1:0]       wr_strb_o,
  output logic                             ram_we_o,
  output logic                             ram_re_o,
  output logic                             led_we_o,
  output logic                             key_we_o,
  // from peripherals
  input  wire  [soc_pkg::DATA_W-1:0]       ram_rdata_i,
  input  wire  [soc_pkg::LED_W-1:0]        led_rdata_i,
  input  wire  [2*soc_pkg::KEY_W-1:0]      key_rdata_i
);
  import soc_pkg::*;

  logic [1:0]        state_q;
  logic              wr_accept;
  logic              rd_accept;
  logic [ADDR_W-1:0] bus_addr;
  logic              hit_ram;
  logic              hit_led;
  logic              hit_key;
  logic              hit_any;
  logic              rd_ram_q;   // pending read comes from RAM
  logic [DATA_W-1:0] reg_rdata;
  logic [DATA_W-1:0] rdata_q;
  logic [1:0]        bresp_q;
  logic [1:0]        rresp_q;

  // only accept from idle, so one transaction at a time
  assign wr_accept = (state_q == ST_IDLE) && awvalid_i && wvalid_i;
  assign rd_accept = (state_q == ST_IDLE) && arvalid_i && !wr_accept;  // write wins

  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign arready_o = rd_accept;

  // shared address path
  assign bus_addr = wr_accept ? awaddr_i : araddr_i;

  assign hit_ram = bus_addr[ADDR_W-1:RAM_ADDR_BITS+2] ==
                   RAM_BASE[ADDR_W-1:RAM_ADDR_BITS+2];
  assign hit_led = bus_addr == LED_ADDR;
  assign hit_key = bus_addr == KEY_ADDR;
  assign hit_any = hit_ram || hit_led || hit_key;

  assign word_addr_o = bus_addr[RAM_ADDR_BITS+1:2];
  assign wr_data_o   = wdata_i;
  assign wr_strb_o   = wstrb_i;

  assign ram_we_o = wr_accept && hit_ram;
  assign led_we_o = wr_accept && hit_led;
  assign key_we_o = wr_accept && hit_key;
  assign ram_re_o = rd_accept && hit_ram;

  // register readback, zero when unmapped
  always_comb
  begin
    reg_rdata = '0;
    if (hit_led)
      reg_rdata[LED_W-1:0] = led_rdata_i;
    else if (hit_key)
      reg_rdata[2*KEY_W-1:0] = key_rdata_i;
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q  <= ST_IDLE;
      rd_ram_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
          if (wr_accept)
            state_q <= ST_WRESP;
          else if (rd_accept)
          begin
            state_q  <= ST_RWAIT;
            rd_ram_q <= hit_ram;
          end
        ST_WRESP:
          if (bready_i)
            state_q <= ST_IDLE;
        ST_RWAIT:
          state_q <= ST_RRESP;  // RAM word valid now
        ST_RRESP:
          if (rready_i)
            state_q <= ST_IDLE;
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_accept)
      bresp_q <= hit_any ? RESP_OKAY : RESP_SLVERR;
    if (rd_accept)
    begin
      rresp_q <= hit_any ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= reg_rdata;
    end
    else if ((state_q == ST_RWAIT) && rd_ram_q)
      rdata_q <= ram_rdata_i;
  end

  assign bvalid_o = state_q == ST_WRESP;
  assign bresp_o  = bresp_q;
  assign rvalid_o = state_q == ST_RRESP;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

  a_resp_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(bvalid_o && rvalid_o));

  a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({ram_we_o, led_we_o, key_we_o}));

endmodule

`default_nettype wire

// File: hw/scratch_ram.sv
`timescale 1ns/10ps
`default_nettype none

module scratch_ram (
  input  wire                               clk,
  input  wire                               we_i,
  input  wire                               re_i,
  input  wire  [soc_pkg::RAM_ADDR_BITS-1:0] addr_i,
  input  wire  [soc_pkg::DATA_W-1:0]        wdata_i,
  input  wire  [soc_pkg::STRB_W-1:0]        wstrb_i,
  output logic [soc_pkg::DATA_W-1:0]        rdata_o
);
  import soc_pkg::*;

  bus_word_u mem_q [0:(1 << RAM_ADDR_BITS)-1];
  bus_word_u wdata_w;

  always_comb
  begin
    wdata_w.word = wdata_i;
  end

  // byte lane writes
  always_ff @(posedge clk)
  begin
    if (we_i)
    begin
      for (int i = 0; i < STRB_W; i++)
      begin
        if (wstrb_i[i])
          mem_q[addr_i].lane[i] <= wdata_w.lane[i];
      end
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk)
  begin
    if (re_i)
      rdata_o <= mem_q[addr_i].word;
  end

  // decoder never reads and writes in the same cycle
  a_no_rw_overlap: assert property (@(posedge clk)
    !(we_i && re_i));

endmodule

`default_nettype wire

// File: hw/led_port.sv
`timescale 1ns/10ps
`default_nettype none

module led_port (
  input  wire                         clk,
  input  wire                         rst_n_i,
  input  wire                         we_i,
  input  wire  [soc_pkg::DATA_W-1:0]  wdata_i,
  input  wire  [soc_pkg::STRB_W-1:0]  wstrb_i,
  output logic [soc_pkg::LED_W-1:0]   led_o,
  output logic [soc_pkg::LED_W-1:0]   rdata_o
);
  import soc_pkg::*;

  bus_word_u wdata_w;

  always_comb
  begin
    wdata_w.word = wdata_i;
  end

  // only byte lane 0 reaches the LEDs
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      led_o <= '0;
    else if (we_i && wstrb_i[0])
      led_o <= wdata_w.lane[0][LED_W-1:0];
  end

  assign rdata_o = led_o;  // readback mirrors pins

endmodule

`default_nettype wire

// File: hw/key_port.sv
`timescale 1ns/10ps
`default_nettype none

module key_port (
  input  wire                          clk,
  input  wire                          rst_n_i,
  input  wire  [soc_pkg::KEY_W-1:0]    key_i,
  input  wire                          we_i,
  input  wire  [soc_pkg::DATA_W-1:0]   wdata_i,
  output logic [2*soc_pkg::KEY_W-1:0]  rdata_o
);
  import soc_pkg::*;

  logic [KEY_W-1:0] sync1_q;
  logic [KEY_W-1:0] sync2_q;
  logic [KEY_W-1:0] level_q;  // third stage, also edge reference
  logic [KEY_W-1:0] flag_q;
  logic [KEY_W-1:0] rise;
  logic [KEY_W-1:0] clr;

  assign rise = sync2_q & ~level_q;
  assign clr  = we_i ? wdata_i[2*KEY_W-1:KEY_W] : '0;  // write one to clear

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sync1_q <= '0;
      sync2_q <= '0;
      level_q <= '0;
      flag_q  <= '0;
    end
    else
    begin
      sync1_q <= key_i;
      sync2_q <= sync1_q;
      level_q <= sync2_q;
      flag_q  <= (flag_q & ~clr) | rise;  // new press beats clear
    end
  end

  assign rdata_o = {flag_q, level_q};

endmodule

`default_nettype wire

// File: hw/soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_top (
  input  wire                         clk,
  input  wire                         rst_n_i,
  input  wire                         awvalid_i,
  input  wire  [soc_pkg::ADDR_W-1:0]  awaddr_i,
  output logic                        awready_o,
  input  wire                         wvalid_i,
  input  wire  [soc_pkg::DATA_W-1:0]  wdata_i,
  input  wire  [soc_pkg::STRB_W-1:0]  wstrb_i,
  output logic                        wready_o,
  output logic                        bvalid_o,
  output logic [1:0]                  bresp_o,
  input  wire                         bready_i,
  input  wire                         arvalid_i,
  input  wire  [soc_pkg::ADDR_W-1:0]  araddr_i,
  output logic                        arready_o,
  output logic                        rvalid_o,
  output logic [soc_pkg::DATA_W-1:0]  rdata_o,
  output logic [1:0]                  rresp_o,
  input  wire                         rready_i,
  input  wire  [soc_pkg::KEY_W-1:0]   key_i,
  output logic [soc_pkg::LED_W-1:0]   led_o
);
  import soc_pkg::*;

  logic [RAM_ADDR_BITS-1:0] word_addr;
  logic [DATA_W-1:0]        wr_data;
  logic [STRB_W-1:0]        wr_strb;
  logic                     ram_we;
  logic                     ram_re;
  logic                     led_we;
  logic                     key_we;
  logic [DATA_W-1:0]        ram_rdata;
  logic [LED_W-1:0]         led_rdata;
  logic [2*KEY_W-1:0]       key_rdata;

  bus_decoder u_decoder (
    .clk(clk), .rst_n_i(rst_n_i),
    .awvalid_i(awvalid_i), .awaddr_i(awaddr_i), .awready_o(awready_o),
    .wvalid_i(wvalid_i), .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wready_o(wready_o),
    .bvalid_o(bvalid_o), .bresp_o(bresp_o), .bready_i(bready_i),
    .arvalid_i(arvalid_i), .araddr_i(araddr_i), .arready_o(arready_o),
    .rvalid_o(rvalid_o), .rdata_o(rdata_o), .rresp_o(rresp_o), .rready_i(rready_i),
    .word_addr_o(word_addr), .wr_data_o(wr_data), .wr_strb_o(wr_strb),
    .ram_we_o(ram_we), .ram_re_o(ram_re), .led_we_o(led_we), .key_we_o(key_we),
    .ram_rdata_i(ram_rdata), .led_rdata_i(led_rdata), .key_rdata_i(key_rdata)
  );

  scratch_ram u_ram (
    .clk(clk), .we_i(ram_we), .re_i(ram_re), .addr_i(word_addr),
    .wdata_i(wr_data), .wstrb_i(wr_strb), .rdata_o(ram_rdata)
  );

  led_port u_led (
    .clk(clk), .rst_n_i(rst_n_i), .we_i(led_we), .wdata_i(wr_data),
    .wstrb_i(wr_strb), .led_o(led_o), .rdata_o(led_rdata)
  );

  key_port u_key (
    .clk(clk), .rst_n_i(rst_n_i), .key_i(key_i), .we_i(key_we),
    .wdata_i(wr_data), .rdata_o(key_rdata)
  );

endmodule

`default_nettype wire

// File: verif/tb_soc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc;
  import soc_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int HS_LIMIT   = 16;  // cycles allowed for any one handshake

  logic              clk;
  logic              rst_n_i;
  logic              awvalid_i;
  logic [ADDR_W-1:0] awaddr_i;
  logic              awready_o;
  logic              wvalid_i;
  logic [DATA_W-1:0] wdata_i;
  logic [STRB_W-1:0] wstrb_i;
  logic              wready_o;
  logic              bvalid_o;
  logic [1:0]        bresp_o;
  logic              bready_i;
  logic              arvalid_i;
  logic [ADDR_W-1:0] araddr_i;
  logic              arready_o;
  logic              rvalid_o;
  logic [DATA_W-1:0] rdata_o;
  logic [1:0]        rresp_o;
  logic              rready_i;
  logic [KEY_W-1:0]  key_i;
  logic [LED_W-1:0]  led_o;

  integer seed = 32'h7e9f_17a6;
  int     errors;
  int     cycle_cnt;
  int     cycle_limit;

  // one entry per case line
  logic [7:0]        op_q[$];
  logic [ADDR_W-1:0] addr_q[$];
  logic [DATA_W-1:0] data_q[$];
  logic [STRB_W-1:0] strb_q[$];
  logic [1:0]        resp_q[$];
  logic [DATA_W-1:0] exp_q[$];

  soc_top u_dut (
    .clk(clk), .rst_n_i(rst_n_i),
    .awvalid_i(awvalid_i), .awaddr_i(awaddr_i), .awready_o(awready_o),
    .wvalid_i(wvalid_i), .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wready_o(wready_o),
    .bvalid_o(bvalid_o), .bresp_o(bresp_o), .bready_i(bready_i),
    .arvalid_i(arvalid_i), .araddr_i(araddr_i), .arready_o(arready_o),
    .rvalid_o(rvalid_o), .rdata_o(rdata_o), .rresp_o(rresp_o), .rready_i(rready_i),
    .key_i(key_i), .led_o(led_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    errors++;
    $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
  endtask

  task automatic settle();
    #(CLK_PERIOD/4);  // sample well away from both edges
  endtask

  task automatic load_cases(output bit loaded);
    int          fd;
    int          rc;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] r;
    logic [31:0] e;
    loaded = 1'b0;
    fd = $fopen("verif/soc_cases.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the case file verif/soc_cases.txt");
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;  // blank or comment
      rc = $sscanf(line, "%c %h %h %h %h %h", op, a, d, s, r, e);
      if (rc != 6)
      begin
        errors++;
        $display("case line could not be parsed: %s", line);
        continue;
      end
      op_q.push_back(op);
      addr_q.push_back(a);
      data_q.push_back(d);
      strb_q.push_back(s[STRB_W-1:0]);
      resp_q.push_back(r[1:0]);
      exp_q.push_back(e);
    end
    $fclose(fd);
    loaded = op_q.size() > 0;
    if (!loaded)
      $display("the case file holds no cases");
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] resp, output bit ok);
    int waited;
    bit accepted;
    ok = 1'b0;
    resp = 2'd0;
    @(negedge clk);
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    waited = 0;
    settle();
    while (!(awready_o && wready_o) && waited < HS_LIMIT)
    begin
      @(negedge clk);
      settle();
      waited++;
    end
    accepted = awready_o && wready_o;
    @(negedge clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    if (!accepted)
    begin
      errors++;
      $display("write to %h was never accepted", addr);
      return;
    end
    bready_i = 1'b1;
    waited = 0;
    settle();
    while (!bvalid_o && waited < HS_LIMIT)
    begin
      @(negedge clk);
      settle();
      waited++;
    end
    ok = bvalid_o;
    resp = bresp_o;
    @(negedge clk);
    bready_i = 1'b0;
    if (!ok)
    begin
      errors++;
      $display("no write response came back for %h", addr);
    end
  endtask

  // R channel must hold still until rready
  task automatic check_r_stable(input logic [31:0] data, input logic [1:0] resp);
    if (rvalid_o !== 1'b1)
    begin
      errors++;
      $display("rvalid_o dropped before rready at %0t", $time);
    end
    if (rdata_o !== data)
      report_mismatch("rdata_o", data, rdata_o);
    if (rresp_o !== resp)
      report_mismatch("rresp_o", {30'h0, resp}, {30'h0, rresp_o});
  endtask

  task automatic do_read(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp, output bit ok);
    int          waited;
    bit          accepted;
    logic [31:0] rnd;
    logic [1:0]  delay;
    ok = 1'b0;
    data = '0;
    resp = 2'd0;
    @(negedge clk);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    waited = 0;
    settle();
    while (!arready_o && waited < HS_LIMIT)
    begin
      @(negedge clk);
      settle();
      waited++;
    end
    accepted = arready_o;
    @(negedge clk);
    arvalid_i = 1'b0;
    if (!accepted)
    begin
      errors++;
      $display("read of %h was never accepted", addr);
      return;
    end
    waited = 0;
    settle();
    while (!rvalid_o && waited < HS_LIMIT)
    begin
      @(negedge clk);
      settle();
      waited++;
    end
    if (!rvalid_o)
    begin
      errors++;
      $display("no read data came back for %h", addr);
      return;
    end
    data = rdata_o;
    resp = rresp_o;
    rnd = $random(seed);
    delay = rnd[1:0];  // 0 to 3 cycles of back-pressure
    repeat (delay)
    begin
      @(negedge clk);
      settle();
      check_r_stable(data, resp);
    end
    @(negedge clk);
    rready_i = 1'b1;
    settle();
    check_r_stable(data, resp);
    @(negedge clk);
    rready_i = 1'b0;
    ok = 1'b1;
  endtask

  task automatic run_case(input int i);
    logic [1:0]  resp;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] addr;
    bit          ok;
    exp  = exp_q[i];
    addr = addr_q[i];
    case (op_q[i])
      "W":
      begin
        do_write(addr, data_q[i], strb_q[i], resp, ok);
        if (ok && resp !== resp_q[i])
          report_mismatch("bresp_o", {30'h0, resp_q[i]}, {30'h0, resp});
        if (ok && addr == LED_ADDR && {24'h0, led_o} !== exp)
          report_mismatch("led_o", exp, {24'h0, led_o});
      end
      "R", "K":
      begin
        if (op_q[i] == "K")
        begin
          data = data_q[i];
          @(negedge clk);
          key_i = data[KEY_W-1:0];
          repeat (4) @(negedge clk);  // sync stages plus edge detect
          addr = KEY_ADDR;
        end
        do_read(addr, data, resp, ok);
        if (ok && resp !== resp_q[i])
          report_mismatch("rresp_o", {30'h0, resp_q[i]}, {30'h0, resp});
        if (ok && data !== exp)
          report_mismatch("rdata_o", exp, data);
        if (ok && addr == LED_ADDR && {24'h0, led_o} !== exp)
          report_mismatch("led_o", exp, {24'h0, led_o});
      end
      default:
      begin
        errors++;
        $display("case %0d has an unknown operation %c", i, op_q[i]);
      end
    endcase
  endtask

  initial
  begin
    bit loaded;
    rst_n_i     = 1'b0;
    awvalid_i   = 1'b0;
    awaddr_i    = '0;
    wvalid_i    = 1'b0;
    wdata_i     = '0;
    wstrb_i     = '0;
    bready_i    = 1'b0;
    arvalid_i   = 1'b0;
    araddr_i    = '0;
    rready_i    = 1'b0;
    key_i       = '0;
    errors      = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    load_cases(loaded);
    if (!loaded)
    begin
      errors++;
    end
    else
    begin
      cycle_limit = 20 * op_q.size() + 100;
      repeat (8) @(negedge clk);
      rst_n_i = 1'b1;
      for (int i = 0; i < op_q.size(); i++)
        run_case(i);
      @(negedge clk);
    end
    $display("%0d errors in %0d cases", errors, op_q.size());
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/soc_cases.txt
# columns: op addr data strb resp expect, all hex; op is W write, R read, K key
# W: expect is led_o after an LED write; K: data drives key_i, then the key register is read
R 10000000 00000000 0 0 00000000 LED after reset
R 10000004 00000000 0 0 00000000 keys low after reset
W 00000000 12345678 f 0 00000000
W 00000004 deadbeef f 0 00000000
W 00000ffc a5a5a5a5 f 0 00000000 top word of the window
R 00000000 00000000 0 0 12345678
R 00000004 00000000 0 0 deadbeef
R 00000ffc 00000000 0 0 a5a5a5a5
W 00000000 aabbccdd 5 0 00000000 lanes 0 and 2
R 00000000 00000000 0 0 12bb56dd
W 00000004 0000cc00 2 0 00000000 lane 1 only
R 00000004 00000000 0 0 deadccef
W 10000000 0000005a 1 0 0000005a
R 10000000 00000000 0 0 0000005a
W 10000000 000000ff e 0 0000005a lane 0 not strobed
R 10000000 00000000 0 0 0000005a
K 10000004 00000001 0 0 00000005 key 0 pressed
K 10000004 00000000 0 0 00000004 released, flag sticks
K 10000004 00000002 0 0 0000000e key 1 pressed
W 10000004 00000004 f 0 00000000 clear flag 0
R 10000004 00000000 0 0 0000000a
K 10000004 00000000 0 0 00000008
W 10000004 00000008 f 0 00000000 clear flag 1
R 10000004 00000000 0 0 00000000
W 20000000 11111111 f 2 00000000 unmapped
R 20000000 00000000 0 2 00000000
R 10000008 00000000 0 2 00000000 past the key register
W 00001000 77777777 f 2 00000000 just past the RAM window
R 00001000 00000000 0 2 00000000
R 00000000 00000000 0 0 12bb56dd
R 00000004 00000000 0 0 deadccef

// File: flist.f
hw/soc_pkg.sv
hw/bus_decoder.sv
hw/scratch_ram.sv
hw/led_port.sv
hw/key_port.sv
hw/soc_top.sv
verif/tb_soc.sv

// File: run.sh
#!/bin/sh
# build and run the SoC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_soc -f flist.f -Mdir obj_dir -o Vtb_soc
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_soc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  echo "simulation reported failures, see $LOG"
  exit 1
fi

echo "simulation finished without failures"
exit 0
